// File: hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

    // instruction field positions
    localparam int OPCODE_LSB = 26;
    localparam int OPCODE_W   = 6;
    localparam int RS_LSB     = 21;
    localparam int RT_LSB     = 16;
    localparam int RD_LSB     = 11;
    localparam int IMM_LSB    = 0;
    localparam int IMM_W      = 16;
    localparam int FUNCT_LSB  = 0;
    localparam int FUNCT_W    = 6;

    // primary opcodes
    localparam logic [OPCODE_W-1:0] OPC_SPECIAL = 6'h00;
    localparam logic [OPCODE_W-1:0] OPC_ADDIU   = 6'h09;
    localparam logic [OPCODE_W-1:0] OPC_ORI     = 6'h0d;
    localparam logic [OPCODE_W-1:0] OPC_LUI     = 6'h0f;
    localparam logic [OPCODE_W-1:0] OPC_LW      = 6'h23;
    localparam logic [OPCODE_W-1:0] OPC_SW      = 6'h2b;

    // SPECIAL function codes
    localparam logic [FUNCT_W-1:0] FN_ADDU = 6'h21;
    localparam logic [FUNCT_W-1:0] FN_SUBU = 6'h23;
    localparam logic [FUNCT_W-1:0] FN_AND  = 6'h24;
    localparam logic [FUNCT_W-1:0] FN_OR   = 6'h25;
    localparam logic [FUNCT_W-1:0] FN_XOR  = 6'h26;
    localparam logic [FUNCT_W-1:0] FN_SLT  = 6'h2a;

    typedef enum logic [3:0] {
        OP_NOP, OP_ADDU, OP_SUBU, OP_AND, OP_OR, OP_XOR,
        OP_SLT, OP_ADDIU, OP_ORI, OP_LUI, OP_LW, OP_SW
    } op_e;

endpackage

`default_nettype wire

// File: hw/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    // memory access carried down the pipe
    typedef enum logic [1:0] {
        MEM_NONE,
        MEM_LOAD,
        MEM_STORE
    } mem_op_e;

endpackage

`default_nettype wire

// File: hw/fetch_unit.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
    input  wire                       clk,
    input  wire                       rst_n,
    input  wire                       en_pc_i,
    input  wire                       en_ifid_i,
    input  wire  [core_pkg::XLEN-1:0] ibus_rddata_i,
    output logic [core_pkg::XLEN-1:0] ibus_address_o,
    output logic                      ibus_read_o,
    output logic [core_pkg::XLEN-1:0] inst_o,
    output logic                      inst_valid_o
);

    logic [core_pkg::XLEN-1:0] pc;
    logic                      fetch_active; // first edge out of reset

    assign ibus_address_o = pc;
    assign ibus_read_o    = fetch_active;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc           <= core_pkg::RESET_PC;
            fetch_active <= 1'b0;
        end else begin
            fetch_active <= 1'b1;
            if (en_pc_i && fetch_active)
                pc <= pc + 32'd4;
        end
    end

    // IF/ID keeps its word while held, bubbles go in at ID/EX
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            inst_o       <= '0;
            inst_valid_o <= 1'b0;
        end else if (en_ifid_i) begin
            inst_o       <= ibus_rddata_i;
            inst_valid_o <= fetch_active;
        end
    end

endmodule

`default_nettype wire

// File: hw/decode_unit.sv
`timescale 1ns/100ps
`default_nettype none

module decode_unit (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire  [core_pkg::XLEN-1:0]        inst_i,
    input  wire                              inst_valid_i,
    input  wire                              en_idex_i,
    input  wire                              bubble_i,
    input  wire  [core_pkg::XLEN-1:0]        rs_value_i,
    input  wire  [core_pkg::XLEN-1:0]        rt_value_i,
    input  wire  [core_pkg::REG_ADDR_W-1:0]  ex_dest_i,
    input  core_pkg::mem_op_e                ex_mem_op_i,
    input  wire  [core_pkg::XLEN-1:0]        ex_result_i,
    input  wire  [core_pkg::REG_ADDR_W-1:0]  mm_dest_i,
    input  core_pkg::mem_op_e                mm_mem_op_i,
    input  wire  [core_pkg::XLEN-1:0]        mm_result_i,
    input  wire  [core_pkg::REG_ADDR_W-1:0]  wb_dest_i,
    input  wire                              wb_we_i,
    input  wire  [core_pkg::XLEN-1:0]        wb_data_i,
    output logic [core_pkg::REG_ADDR_W-1:0]  rs_addr_o,
    output logic [core_pkg::REG_ADDR_W-1:0]  rt_addr_o,
    output isa_pkg::op_e                     ex_op_o,
    output core_pkg::mem_op_e                ex_mem_op_o,
    output logic [core_pkg::REG_ADDR_W-1:0]  ex_dest_o,
    output logic [core_pkg::XLEN-1:0]        ex_a_o,
    output logic [core_pkg::XLEN-1:0]        ex_b_o,
    output logic [core_pkg::XLEN-1:0]        ex_store_data_o
);

    logic [isa_pkg::OPCODE_W-1:0]    opcode;
    logic [isa_pkg::FUNCT_W-1:0]     funct;
    logic [core_pkg::REG_ADDR_W-1:0] rs_f, rt_f, rd_f;
    logic [isa_pkg::IMM_W-1:0]       imm_f;

    isa_pkg::op_e                    id_op;
    core_pkg::mem_op_e               id_mem_op;
    logic [core_pkg::REG_ADDR_W-1:0] id_dest;
    logic [core_pkg::XLEN-1:0]       id_imm;
    logic                            uses_rs, uses_rt, use_imm;
    logic [core_pkg::XLEN-1:0]       rs_fwd, rt_fwd;

    assign opcode = inst_i[isa_pkg::OPCODE_LSB +: isa_pkg::OPCODE_W];
    assign funct  = inst_i[isa_pkg::FUNCT_LSB +: isa_pkg::FUNCT_W];
    assign rs_f   = inst_i[isa_pkg::RS_LSB +: core_pkg::REG_ADDR_W];
    assign rt_f   = inst_i[isa_pkg::RT_LSB +: core_pkg::REG_ADDR_W];
    assign rd_f   = inst_i[isa_pkg::RD_LSB +: core_pkg::REG_ADDR_W];
    assign imm_f  = inst_i[isa_pkg::IMM_LSB +: isa_pkg::IMM_W];

    always_comb begin
        id_op = isa_pkg::OP_NOP; // anything unknown is a nop
        if (inst_valid_i) begin
            case (opcode)
                isa_pkg::OPC_SPECIAL: begin
                    case (funct)
                        isa_pkg::FN_ADDU: id_op = isa_pkg::OP_ADDU;
                        isa_pkg::FN_SUBU: id_op = isa_pkg::OP_SUBU;
                        isa_pkg::FN_AND:  id_op = isa_pkg::OP_AND;
                        isa_pkg::FN_OR:   id_op = isa_pkg::OP_OR;
                        isa_pkg::FN_XOR:  id_op = isa_pkg::OP_XOR;
                        isa_pkg::FN_SLT:  id_op = isa_pkg::OP_SLT;
                        default:          id_op = isa_pkg::OP_NOP;
                    endcase
                end
                isa_pkg::OPC_ADDIU: id_op = isa_pkg::OP_ADDIU;
                isa_pkg::OPC_ORI:   id_op = isa_pkg::OP_ORI;
                isa_pkg::OPC_LUI:   id_op = isa_pkg::OP_LUI;
                isa_pkg::OPC_LW:    id_op = isa_pkg::OP_LW;
                isa_pkg::OPC_SW:    id_op = isa_pkg::OP_SW;
                default:            id_op = isa_pkg::OP_NOP;
            endcase
        end
    end

    // operand usage, destination and immediate per operation
    always_comb begin
        uses_rs   = 1'b0;
        uses_rt   = 1'b0;
        use_imm   = 1'b1;
        id_dest   = rt_f;
        id_mem_op = core_pkg::MEM_NONE;
        id_imm    = {{16{imm_f[15]}}, imm_f}; // sign extended by default
        case (id_op)
            isa_pkg::OP_ADDU, isa_pkg::OP_SUBU, isa_pkg::OP_AND,
            isa_pkg::OP_OR, isa_pkg::OP_XOR, isa_pkg::OP_SLT: begin
                uses_rs = 1'b1;
                uses_rt = 1'b1;
                use_imm = 1'b0;
                id_dest = rd_f;
            end
            isa_pkg::OP_ADDIU: uses_rs = 1'b1;
            isa_pkg::OP_ORI: begin
                uses_rs = 1'b1;
                id_imm  = {16'b0, imm_f};
            end
            isa_pkg::OP_LUI: id_imm = {16'b0, imm_f}; // shifted in EX
            isa_pkg::OP_LW: begin
                uses_rs   = 1'b1;
                id_mem_op = core_pkg::MEM_LOAD;
            end
            isa_pkg::OP_SW: begin
                uses_rs   = 1'b1;
                uses_rt   = 1'b1;
                id_dest   = '0;
                id_mem_op = core_pkg::MEM_STORE;
            end
            default: id_dest = '0;
        endcase
    end

    // unused fields read r0 so they never match a hazard
    assign rs_addr_o = uses_rs ? rs_f : '0;
    assign rt_addr_o = uses_rt ? rt_f : '0;

    // youngest producer wins, load results are not ready before WB
    function automatic logic [core_pkg::XLEN-1:0] fwd_value(
        input logic [core_pkg::REG_ADDR_W-1:0] addr,
        input logic [core_pkg::XLEN-1:0]       rf_value
    );
        logic [core_pkg::XLEN-1:0] value;
        value = rf_value;
        if (addr != '0) begin
            if (ex_dest_i == addr && ex_mem_op_i != core_pkg::MEM_LOAD)
                value = ex_result_i;
            else if (mm_dest_i == addr && mm_mem_op_i != core_pkg::MEM_LOAD)
                value = mm_result_i;
            else if (wb_we_i && wb_dest_i == addr)
                value = wb_data_i;
        end
        return value;
    endfunction

    always_comb begin
        rs_fwd = fwd_value(rs_addr_o, rs_value_i);
        rt_fwd = fwd_value(rt_addr_o, rt_value_i);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_op_o     <= isa_pkg::OP_NOP;
            ex_mem_op_o <= core_pkg::MEM_NONE;
            ex_dest_o   <= '0;
        end else if (en_idex_i) begin
            ex_op_o     <= bubble_i ? isa_pkg::OP_NOP : id_op;
            ex_mem_op_o <= bubble_i ? core_pkg::MEM_NONE : id_mem_op;
            ex_dest_o   <= bubble_i ? '0 : id_dest;
        end
    end

    always_ff @(posedge clk) begin
        if (en_idex_i) begin
            ex_a_o          <= rs_fwd;
            ex_b_o          <= use_imm ? id_imm : rt_fwd;
            ex_store_data_o <= rt_fwd;
        end
    end

endmodule

`default_nettype wire

// File: hw/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  wire                             clk,
    input  wire [core_pkg::REG_ADDR_W-1:0]  raddr1_i,
    input  wire [core_pkg::REG_ADDR_W-1:0]  raddr2_i,
    input  wire                             we_i,
    input  wire [core_pkg::REG_ADDR_W-1:0]  waddr_i,
    input  wire [core_pkg::XLEN-1:0]        wdata_i,
    output logic [core_pkg::XLEN-1:0]       rdata1_o,
    output logic [core_pkg::XLEN-1:0]       rdata2_o
);

    logic [core_pkg::XLEN-1:0] regs [1:core_pkg::NUM_REGS-1]; // no storage for r0

    always_ff @(posedge clk) begin
        if (we_i && waddr_i != '0)
            regs[waddr_i] <= wdata_i;
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

// File: hw/execute_unit.sv
`timescale 1ns/100ps
`default_nettype none

module execute_unit (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              en_exmm_i,
    input  isa_pkg::op_e                     op_i,
    input  core_pkg::mem_op_e                mem_op_i,
    input  wire  [core_pkg::REG_ADDR_W-1:0]  dest_i,
    input  wire  [core_pkg::XLEN-1:0]        a_i,
    input  wire  [core_pkg::XLEN-1:0]        b_i,
    input  wire  [core_pkg::XLEN-1:0]        store_data_i,
    output logic [core_pkg::XLEN-1:0]        ex_result_o,
    output core_pkg::mem_op_e                mm_mem_op_o,
    output logic [core_pkg::REG_ADDR_W-1:0]  mm_dest_o,
    output logic [core_pkg::XLEN-1:0]        mm_result_o,
    output logic [core_pkg::XLEN-1:0]        mm_store_data_o
);

    always_comb begin
        case (op_i)
            isa_pkg::OP_ADDU, isa_pkg::OP_ADDIU,
            isa_pkg::OP_LW, isa_pkg::OP_SW: ex_result_o = a_i + b_i; // also the address
            isa_pkg::OP_SUBU: ex_result_o = a_i - b_i;
            isa_pkg::OP_AND:  ex_result_o = a_i & b_i;
            isa_pkg::OP_OR,
            isa_pkg::OP_ORI:  ex_result_o = a_i | b_i;
            isa_pkg::OP_XOR:  ex_result_o = a_i ^ b_i;
            isa_pkg::OP_SLT:  ex_result_o = {31'b0, $signed(a_i) < $signed(b_i)};
            isa_pkg::OP_LUI:  ex_result_o = {b_i[15:0], 16'b0};
            default:          ex_result_o = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mm_mem_op_o <= core_pkg::MEM_NONE;
            mm_dest_o   <= '0;
        end else if (en_exmm_i) begin
            mm_mem_op_o <= mem_op_i;
            mm_dest_o   <= dest_i;
        end
    end

    always_ff @(posedge clk) begin
        if (en_exmm_i) begin
            mm_result_o     <= ex_result_o;
            mm_store_data_o <= store_data_i;
        end
    end

endmodule

`default_nettype wire

// File: hw/mem_wb_unit.sv
`timescale 1ns/100ps
`default_nettype none

module mem_wb_unit (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              en_mmwb_i,
    input  core_pkg::mem_op_e                mem_op_i,
    input  wire  [core_pkg::REG_ADDR_W-1:0]  dest_i,
    input  wire  [core_pkg::XLEN-1:0]        result_i,
    input  wire  [core_pkg::XLEN-1:0]        store_data_i,
    input  wire  [core_pkg::XLEN-1:0]        dbus_rddata_i,
    output logic [core_pkg::XLEN-1:0]        dbus_address_o,
    output logic [core_pkg::XLEN-1:0]        dbus_wrdata_o,
    output logic                             dbus_read_o,
    output logic                             dbus_write_o,
    output logic                             wb_we_o,
    output logic [core_pkg::REG_ADDR_W-1:0]  wb_dest_o,
    output logic [core_pkg::XLEN-1:0]        wb_data_o
);

    // EX/MEM holds while stalled, so the bus request holds with it
    assign dbus_address_o = result_i;
    assign dbus_wrdata_o  = store_data_i;
    assign dbus_read_o    = (mem_op_i == core_pkg::MEM_LOAD);
    assign dbus_write_o   = (mem_op_i == core_pkg::MEM_STORE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_we_o   <= 1'b0;
            wb_dest_o <= '0;
        end else if (en_mmwb_i) begin
            wb_we_o   <= (mem_op_i != core_pkg::MEM_STORE) && (dest_i != '0);
            wb_dest_o <= dest_i;
        end
    end

    always_ff @(posedge clk) begin
        if (en_mmwb_i)
            wb_data_o <= dbus_read_o ? dbus_rddata_i : result_i; // load data sampled here
    end

endmodule

`default_nettype wire

// File: hw/hazard_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module hazard_ctrl (
    input  wire                             dbus_stall_i,
    input  wire [core_pkg::REG_ADDR_W-1:0]  rs_addr_i,
    input  wire [core_pkg::REG_ADDR_W-1:0]  rt_addr_i,
    input  wire [core_pkg::REG_ADDR_W-1:0]  ex_dest_i,
    input  core_pkg::mem_op_e               ex_mem_op_i,
    input  wire [core_pkg::REG_ADDR_W-1:0]  mm_dest_i,
    input  core_pkg::mem_op_e               mm_mem_op_i,
    output logic                            en_pc_o,
    output logic                            en_ifid_o,
    output logic                            en_idex_o,
    output logic                            en_exmm_o,
    output logic                            en_mmwb_o,
    output logic                            bubble_o
);

    logic ex_load_hit, mm_load_hit;

    assign ex_load_hit = (ex_mem_op_i == core_pkg::MEM_LOAD) && (ex_dest_i != '0) &&
                         (ex_dest_i == rs_addr_i || ex_dest_i == rt_addr_i);
    assign mm_load_hit = (mm_mem_op_i == core_pkg::MEM_LOAD) && (mm_dest_i != '0) &&
                         (mm_dest_i == rs_addr_i || mm_dest_i == rt_addr_i);

    always_comb begin
        if (dbus_stall_i) begin
            {en_pc_o, en_ifid_o, en_idex_o, en_exmm_o, en_mmwb_o} = 5'b00000;
            bubble_o = 1'b0;
        end else if (ex_load_hit || mm_load_hit) begin
            {en_pc_o, en_ifid_o, en_idex_o, en_exmm_o, en_mmwb_o} = 5'b00111;
            bubble_o = 1'b1; // nop into EX
        end else begin
            {en_pc_o, en_ifid_o, en_idex_o, en_exmm_o, en_mmwb_o} = 5'b11111;
            bubble_o = 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: hw/mips_core.sv
`timescale 1ns/100ps
`default_nettype none

module mips_core (
    input  wire                       clk,
    input  wire                       rst_n,
    output logic [core_pkg::XLEN-1:0] ibus_address_o,
    output logic                      ibus_read_o,
    input  wire  [core_pkg::XLEN-1:0] ibus_rddata_i,
    output logic [core_pkg::XLEN-1:0] dbus_address_o,
    output logic [core_pkg::XLEN-1:0] dbus_wrdata_o,
    output logic                      dbus_read_o,
    output logic                      dbus_write_o,
    input  wire  [core_pkg::XLEN-1:0] dbus_rddata_i,
    input  wire                       dbus_stall_i
);

    logic en_pc, en_ifid, en_idex, en_exmm, en_mmwb, bubble;

    logic [core_pkg::XLEN-1:0] if_inst;
    logic                      if_inst_valid;

    logic [core_pkg::REG_ADDR_W-1:0] rs_addr, rt_addr;
    logic [core_pkg::XLEN-1:0]       rs_value, rt_value;

    isa_pkg::op_e                    ex_op;
    core_pkg::mem_op_e               ex_mem_op;
    logic [core_pkg::REG_ADDR_W-1:0] ex_dest;
    logic [core_pkg::XLEN-1:0]       ex_a, ex_b, ex_store_data, ex_result;

    core_pkg::mem_op_e               mm_mem_op;
    logic [core_pkg::REG_ADDR_W-1:0] mm_dest;
    logic [core_pkg::XLEN-1:0]       mm_result, mm_store_data;

    logic                            wb_we;
    logic [core_pkg::REG_ADDR_W-1:0] wb_dest;
    logic [core_pkg::XLEN-1:0]       wb_data;

    fetch_unit u_fetch (
        .clk            (clk),
        .rst_n          (rst_n),
        .en_pc_i        (en_pc),
        .en_ifid_i      (en_ifid),
        .ibus_rddata_i  (ibus_rddata_i),
        .ibus_address_o (ibus_address_o),
        .ibus_read_o    (ibus_read_o),
        .inst_o         (if_inst),
        .inst_valid_o   (if_inst_valid)
    );

    decode_unit u_decode (
        .clk             (clk),
        .rst_n           (rst_n),
        .inst_i          (if_inst),
        .inst_valid_i    (if_inst_valid),
        .en_idex_i       (en_idex),
        .bubble_i        (bubble),
        .rs_value_i      (rs_value),
        .rt_value_i      (rt_value),
        .ex_dest_i       (ex_dest),
        .ex_mem_op_i     (ex_mem_op),
        .ex_result_i     (ex_result),
        .mm_dest_i       (mm_dest),
        .mm_mem_op_i     (mm_mem_op),
        .mm_result_i     (mm_result),
        .wb_dest_i       (wb_dest),
        .wb_we_i         (wb_we),
        .wb_data_i       (wb_data),
        .rs_addr_o       (rs_addr),
        .rt_addr_o       (rt_addr),
        .ex_op_o         (ex_op),
        .ex_mem_op_o     (ex_mem_op),
        .ex_dest_o       (ex_dest),
        .ex_a_o          (ex_a),
        .ex_b_o          (ex_b),
        .ex_store_data_o (ex_store_data)
    );

    reg_file u_regs (
        .clk      (clk),
        .raddr1_i (rs_addr),
        .raddr2_i (rt_addr),
        .we_i     (wb_we),
        .waddr_i  (wb_dest),
        .wdata_i  (wb_data),
        .rdata1_o (rs_value),
        .rdata2_o (rt_value)
    );

    execute_unit u_execute (
        .clk             (clk),
        .rst_n           (rst_n),
        .en_exmm_i       (en_exmm),
        .op_i            (ex_op),
        .mem_op_i        (ex_mem_op),
        .dest_i          (ex_dest),
        .a_i             (ex_a),
        .b_i             (ex_b),
        .store_data_i    (ex_store_data),
        .ex_result_o     (ex_result),
        .mm_mem_op_o     (mm_mem_op),
        .mm_dest_o       (mm_dest),
        .mm_result_o     (mm_result),
        .mm_store_data_o (mm_store_data)
    );

    mem_wb_unit u_mem_wb (
        .clk            (clk),
        .rst_n          (rst_n),
        .en_mmwb_i      (en_mmwb),
        .mem_op_i       (mm_mem_op),
        .dest_i         (mm_dest),
        .result_i       (mm_result),
        .store_data_i   (mm_store_data),
        .dbus_rddata_i  (dbus_rddata_i),
        .dbus_address_o (dbus_address_o),
        .dbus_wrdata_o  (dbus_wrdata_o),
        .dbus_read_o    (dbus_read_o),
        .dbus_write_o   (dbus_write_o),
        .wb_we_o        (wb_we),
        .wb_dest_o      (wb_dest),
        .wb_data_o      (wb_data)
    );

    hazard_ctrl u_hazard (
        .dbus_stall_i (dbus_stall_i),
        .rs_addr_i    (rs_addr),
        .rt_addr_i    (rt_addr),
        .ex_dest_i    (ex_dest),
        .ex_mem_op_i  (ex_mem_op),
        .mm_dest_i    (mm_dest),
        .mm_mem_op_i  (mm_mem_op),
        .en_pc_o      (en_pc),
        .en_ifid_o    (en_ifid),
        .en_idex_o    (en_idex),
        .en_exmm_o    (en_exmm),
        .en_mmwb_o    (en_mmwb),
        .bubble_o     (bubble)
    );

endmodule

`default_nettype wire

// File: testbench/mips_core_chk.sv
`timescale 1ns/100ps
`default_nettype none

module mips_core_chk (
    input wire                      clk,
    input wire                      rst_n,
    input wire [core_pkg::XLEN-1:0] ibus_address_o,
    input wire [core_pkg::XLEN-1:0] dbus_address_o,
    input wire [core_pkg::XLEN-1:0] dbus_wrdata_o,
    input wire                      dbus_read_o,
    input wire                      dbus_write_o,
    input wire                      dbus_stall_i
);

    int unsigned fail_count = 0; // failed assertions so far

    strobe_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(dbus_read_o && dbus_write_o))
        else begin
            $error("dbus read and write strobes high together");
            fail_count++;
        end

    // a stalled request holds until accepted
    stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        dbus_stall_i |=> $stable(dbus_read_o) && $stable(dbus_write_o) &&
                         $stable(dbus_address_o) && $stable(dbus_wrdata_o))
        else begin
            $error("dbus request changed while stalled");
            fail_count++;
        end

    reset_quiet: assert property (@(posedge clk)
        !rst_n |=> !dbus_read_o && !dbus_write_o)
        else begin
            $error("dbus strobe high during reset");
            fail_count++;
        end

    ibus_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        ibus_address_o[1:0] == 2'b00)
        else begin
            $error("ibus address not word aligned");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: testbench/tb_mips_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_mips_core;

    localparam int N_TESTS         = 8;
    localparam int BODY_LEN        = 40;
    localparam int PROG_LEN        = 31 + BODY_LEN + 31; // init, body, register dump
    localparam int IMEM_WORDS      = 256;
    localparam int DMEM_WORDS      = 1024;
    localparam int DUMP_BASE       = 32'h800;
    localparam int RESET_CYCLES    = 16;
    localparam int WATCHDOG_CYCLES = 20 * N_TESTS * PROG_LEN;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic [core_pkg::XLEN-1:0] ibus_address, ibus_rddata;
    logic                      ibus_read;
    logic [core_pkg::XLEN-1:0] dbus_address, dbus_wrdata, dbus_rddata;
    logic                      dbus_read, dbus_write, dbus_stall;

    logic [31:0] imem [0:IMEM_WORDS-1];
    logic [31:0] dmem [0:DMEM_WORDS-1];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    int          seen, checks, errors, test_errors, stall_left;
    logic        in_access;
    logic        reset_seen;    // at least one reset edge has passed
    logic        fetch_running; // core has left reset on an earlier edge
    string       test_name;

    always #5 clk = ~clk;

    assign ibus_rddata = imem[ibus_address[9:2]]; // combinational fetch
    assign dbus_rddata = dmem[dbus_address[11:2]];

    mips_core dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .ibus_address_o (ibus_address),
        .ibus_read_o    (ibus_read),
        .ibus_rddata_i  (ibus_rddata),
        .dbus_address_o (dbus_address),
        .dbus_wrdata_o  (dbus_wrdata),
        .dbus_read_o    (dbus_read),
        .dbus_write_o   (dbus_write),
        .dbus_rddata_i  (dbus_rddata),
        .dbus_stall_i   (dbus_stall)
    );

    bind mips_core mips_core_chk u_chk (
        .clk            (clk),
        .rst_n          (rst_n),
        .ibus_address_o (ibus_address_o),
        .dbus_address_o (dbus_address_o),
        .dbus_wrdata_o  (dbus_wrdata_o),
        .dbus_read_o    (dbus_read_o),
        .dbus_write_o   (dbus_write_o),
        .dbus_stall_i   (dbus_stall_i)
    );

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("** Error: %s %s expected %08h actual %08h",
                     test_name, what, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    function automatic logic [31:0] r_type_word(input logic [5:0] funct,
                                                input logic [4:0] rd, rs, rt);
        return {isa_pkg::OPC_SPECIAL, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [5:0] opc, input logic [4:0] rt, rs,
                                                input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    // mostly r0..r7 so that neighbours depend on each other
    function automatic logic [4:0] pick_reg();
        if ($urandom_range(3, 0) != 0)
            return 5'($urandom_range(7, 0));
        return 5'($urandom_range(31, 0));
    endfunction

    function automatic logic [31:0] random_inst();
        logic [4:0]  rd, rs, rt;
        logic [15:0] imm, offset;
        logic [31:0] word;
        rd     = pick_reg();
        rs     = pick_reg();
        rt     = pick_reg();
        imm    = 16'($urandom);
        offset = {6'd0, 8'($urandom_range(255, 0)), 2'b00}; // load/store area below DUMP_BASE
        case ($urandom_range(10, 0))
            0:       word = r_type_word(isa_pkg::FN_ADDU, rd, rs, rt);
            1:       word = r_type_word(isa_pkg::FN_SUBU, rd, rs, rt);
            2:       word = r_type_word(isa_pkg::FN_AND, rd, rs, rt);
            3:       word = r_type_word(isa_pkg::FN_OR, rd, rs, rt);
            4:       word = r_type_word(isa_pkg::FN_XOR, rd, rs, rt);
            5:       word = r_type_word(isa_pkg::FN_SLT, rd, rs, rt);
            6:       word = i_type_word(isa_pkg::OPC_ADDIU, rt, rs, imm);
            7:       word = i_type_word(isa_pkg::OPC_ORI, rt, rs, imm);
            8:       word = i_type_word(isa_pkg::OPC_LUI, rt, 5'd0, imm);
            9:       word = i_type_word(isa_pkg::OPC_LW, rt, 5'd0, offset);
            default: word = i_type_word(isa_pkg::OPC_SW, rt, 5'd0, offset);
        endcase
        return word;
    endfunction

    task automatic load_program();
        int pc;
        for (int i = 0; i < IMEM_WORDS; i++)
            imem[i] = {6'h3f, 26'(i)}; // undecodable, runs as nop
        pc = 0;
        for (int r = 1; r < 32; r++) begin
            imem[pc] = i_type_word(isa_pkg::OPC_ADDIU, 5'(r), 5'd0, 16'($urandom));
            pc++;
        end
        for (int k = 0; k < BODY_LEN; k++) begin
            imem[pc] = random_inst();
            pc++;
        end
        for (int r = 1; r < 32; r++) begin
            imem[pc] = i_type_word(isa_pkg::OPC_SW, 5'(r), 5'd0, 16'(DUMP_BASE + 4 * r));
            pc++;
        end
    endtask

    // executes the program in order and lists every store it makes
    function automatic int run_reference();
        logic [31:0] regs [0:31];
        logic [31:0] mem [0:DMEM_WORDS-1];
        logic [31:0] inst, a, b, simm, zimm, res, addr;
        logic [5:0]  opc, fn;
        logic [4:0]  rs, rt, rd, dest;
        logic        wr;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        for (int i = 0; i < DMEM_WORDS; i++)
            mem[i] = dmem[i];
        exp_addr.delete();
        exp_data.delete();
        for (int pc = 0; pc < PROG_LEN; pc++) begin
            inst = imem[pc];
            opc  = inst[isa_pkg::OPCODE_LSB +: isa_pkg::OPCODE_W];
            fn   = inst[isa_pkg::FUNCT_LSB +: isa_pkg::FUNCT_W];
            rs   = inst[isa_pkg::RS_LSB +: 5];
            rt   = inst[isa_pkg::RT_LSB +: 5];
            rd   = inst[isa_pkg::RD_LSB +: 5];
            a    = regs[rs];
            b    = regs[rt];
            simm = {{16{inst[15]}}, inst[15:0]};
            zimm = {16'd0, inst[15:0]};
            addr = a + simm;
            wr   = 1'b1;
            dest = rt;
            res  = '0;
            case (opc)
                isa_pkg::OPC_SPECIAL: begin
                    dest = rd;
                    case (fn)
                        isa_pkg::FN_ADDU: res = a + b;
                        isa_pkg::FN_SUBU: res = a - b;
                        isa_pkg::FN_AND:  res = a & b;
                        isa_pkg::FN_OR:   res = a | b;
                        isa_pkg::FN_XOR:  res = a ^ b;
                        isa_pkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        default:          wr = 1'b0;
                    endcase
                end
                isa_pkg::OPC_ADDIU: res = addr;
                isa_pkg::OPC_ORI:   res = a | zimm;
                isa_pkg::OPC_LUI:   res = {inst[15:0], 16'd0};
                isa_pkg::OPC_LW:    res = mem[addr[11:2]];
                isa_pkg::OPC_SW: begin
                    wr = 1'b0;
                    mem[addr[11:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                default: wr = 1'b0;
            endcase
            if (wr && dest != 5'd0)
                regs[dest] = res;
        end
        return exp_addr.size();
    endfunction

    // 0 to 3 stall cycles for each new data-bus request
    always @(negedge clk) begin
        if (rst_n && (dbus_read || dbus_write) && !in_access) begin
            in_access  = 1'b1;
            stall_left = $urandom_range(3, 0);
        end
        dbus_stall <= (stall_left != 0);
        if (stall_left != 0)
            stall_left--;
    end

    // checks the strobes and compares accepted stores with the reference list
    always @(posedge clk) begin
        if (!rst_n) begin
            if (reset_seen && dbus_write !== 1'b0) begin
                $display("%s: write strobe seen during reset", test_name);
                errors++;
                test_errors++;
            end
            reset_seen    = 1'b1;
            fetch_running = 1'b0;
            in_access     = 1'b0;
        end else begin
            if (fetch_running)
                check_value("ibus read strobe", 32'd1, {31'd0, ibus_read});
            fetch_running = 1'b1; // core leaves reset on this edge
            if ((dbus_read || dbus_write) && !dbus_stall) begin
                in_access = 1'b0;
                if (dbus_write) begin
                    if (seen >= exp_addr.size()) begin
                        $display("%s: store to %08h after all expected stores were seen",
                                 test_name, dbus_address);
                        errors++;
                        test_errors++;
                    end else begin
                        check_value($sformatf("store %0d address", seen), exp_addr[seen],
                                    dbus_address);
                        check_value($sformatf("store %0d data", seen), exp_data[seen],
                                    dbus_wrdata);
                    end
                    seen++;
                    dmem[dbus_address[11:2]] = dbus_wrdata;
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles with stores still missing",
                 WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int seed_ret;
        int n_exp;
        seed_ret      = $urandom(32'heb58_eed9);
        rst_n         = 1'b0;
        dbus_stall    = 1'b0;
        in_access     = 1'b0;
        reset_seen    = 1'b0;
        fetch_running = 1'b0;
        stall_left    = 0;
        seen          = 0;
        checks        = 0;
        errors        = 0;
        test_errors   = 0;
        test_name     = "setup";
        for (int i = 0; i < DMEM_WORDS; i++)
            dmem[i] = $urandom;
        for (int t = 0; t < N_TESTS; t++) begin
            @(negedge clk);
            rst_n       = 1'b0;
            test_name   = $sformatf("test%0d", t);
            test_errors = 0;
            load_program();
            n_exp = run_reference();
            seen  = 0;
            repeat (RESET_CYCLES) @(negedge clk);
            rst_n = 1'b1;
            while (seen < n_exp)
                @(negedge clk);
            repeat (4) @(negedge clk); // room for a stray store
            $display("%s done: %0d stores checked, %0d mismatches", test_name, n_exp,
                     test_errors);
        end
        errors += dut.u_chk.fail_count;
        $display("tests %0d, checks %0d, errors %0d", N_TESTS, checks, errors);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
hw/isa_pkg.sv
hw/core_pkg.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/reg_file.sv
hw/execute_unit.sv
hw/mem_wb_unit.sv
hw/hazard_ctrl.sv
hw/mips_core.sv
testbench/mips_core_chk.sv
testbench/tb_mips_core.sv

// File: Bender.yml
package:
  name: mips_core

sources:
  - files:
      - hw/isa_pkg.sv
      - hw/core_pkg.sv
      - hw/fetch_unit.sv
      - hw/decode_unit.sv
      - hw/reg_file.sv
      - hw/execute_unit.sv
      - hw/mem_wb_unit.sv
      - hw/hazard_ctrl.sv
      - hw/mips_core.sv
  - target: test
    files:
      - testbench/mips_core_chk.sv
      - testbench/tb_mips_core.sv
